// ==== mem_tester_config.svh ====
`ifndef MEM_TESTER_CONFIG_SVH
`define MEM_TESTER_CONFIG_SVH

// width of one word on the app data bus
`define MT_DATA_W 128

// app address, counted in 2-byte units
`define MT_ADDR_W 27

// data words per burst
`define MT_BURST_LEN 8

// address advance per burst of 8 words
`define MT_ADDR_STEP 64

// bursts covered by one pass over the test region
`define MT_TEST_BURSTS 16

// first state of the pattern LFSR
`define MT_LFSR_SEED 128'h0123_4567_890A_BCDE_FEDC_BA98_7654_3210

// read bursts allowed in flight at once
`define MT_MAX_RD_OUT 2

`endif

// ==== mem_port_pkg.sv ====
`default_nettype none

`include "mem_tester_config.svh"

package mem_port_pkg;

  // opcodes of the native app port
  typedef enum logic [2:0] {
    MEM_CMD_WR = 3'h0,
    MEM_CMD_RD = 3'h1
  } mem_cmd_e;

  // controller split of one address word
  typedef struct packed {
    logic [13:0] row;
    logic [2:0]  bank;
    logic [9:0]  col;
  } mem_rbc_t;

  // same address seen linearly or as row/bank/col
  typedef union packed {
    logic [`MT_ADDR_W-1:0] lin;
    mem_rbc_t              rbc;
  } mem_addr_u;

  typedef struct packed {
    mem_cmd_e              cmd;
    logic [`MT_ADDR_W-1:0] addr;
  } mem_req_t;

  typedef logic [`MT_DATA_W-1:0] mem_wdata_t;

  // bank moves to the top, row and column follow
  function automatic logic [`MT_ADDR_W-1:0] phys_addr(input mem_addr_u a);
    return {a.rbc.bank, a.rbc.row, a.rbc.col};
  endfunction

endpackage

`default_nettype wire

// ==== mem_test_pkg.sv ====
`default_nettype none

`include "mem_tester_config.svh"

package mem_test_pkg;

  // overall run phases
  typedef enum logic [2:0] {
    WAIT_CALIB = 3'd0,
    FILL       = 3'd1,
    CHECK      = 3'd2,
    INV_FILL   = 3'd3,
    INV_CHECK  = 3'd4,
    DONE       = 3'd5
  } test_phase_e;

  typedef struct packed {
    test_phase_e           phase;
    logic                  done;
    logic                  pass;
    // linear address of the first bad burst
    logic [`MT_ADDR_W-1:0] fail_addr;
  } test_status_t;

  // shift left, feedback taps 68, 67, 66 and 63
  function automatic logic [`MT_DATA_W-1:0] lfsr_next(input logic [`MT_DATA_W-1:0] v);
    return {v[`MT_DATA_W-2:0], v[68] ^ v[67] ^ v[66] ^ v[63]};
  endfunction

  // linear start address of a burst index
  function automatic logic [`MT_ADDR_W-1:0] burst_addr(input logic [`MT_ADDR_W-1:0] idx);
    return `MT_ADDR_W'(idx * `MT_ADDR_STEP);
  endfunction

endpackage

`default_nettype wire

// ==== fill_engine.sv ====
`default_nettype none

`include "mem_tester_config.svh"

module fill_engine (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start_i,
  input  logic                     invert_i,
  output logic                     wdata_valid_o,
  output mem_port_pkg::mem_wdata_t wdata_o,
  input  logic                     wdata_rdy_i,
  output logic                     cmd_valid_o,
  output mem_port_pkg::mem_req_t   req_o,
  input  logic                     cmd_rdy_i,
  output logic                     done_o
);

  import mem_port_pkg::*;
  import mem_test_pkg::*;

  localparam int WORD_W  = $clog2(`MT_BURST_LEN);
  localparam int BURST_W = $clog2(`MT_TEST_BURSTS + 1);

  typedef enum logic [1:0] {
    F_IDLE,
    F_DATA,
    F_CMD
  } fill_state_e;

  fill_state_e           state_q;
  logic [WORD_W-1:0]     word_q;
  logic [BURST_W-1:0]    burst_q;
  logic [`MT_DATA_W-1:0] lfsr_q;
  logic                  done_q;
  mem_addr_u             addr;
  logic                  wr_fire;
  logic                  cmd_fire;
  logic                  last_word;
  logic                  last_burst;

  assign wr_fire    = wdata_valid_o && wdata_rdy_i;
  assign cmd_fire   = cmd_valid_o && cmd_rdy_i;
  assign last_word  = (word_q == WORD_W'(`MT_BURST_LEN - 1));
  assign last_burst = (burst_q == BURST_W'(`MT_TEST_BURSTS - 1));

  assign wdata_valid_o = (state_q == F_DATA);
  assign cmd_valid_o   = (state_q == F_CMD);

  // next word of the sequence, complemented in the inverse pass
  assign wdata_o = invert_i ? ~lfsr_next(lfsr_q) : lfsr_next(lfsr_q);

  assign addr.lin = burst_addr(`MT_ADDR_W'(burst_q));
  assign req_o    = '{cmd: MEM_CMD_WR, addr: phys_addr(addr)};
  assign done_o   = done_q;

  // data words first, then the write command of that burst
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= F_IDLE;
      word_q  <= '0;
      burst_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        F_IDLE: begin
          if (start_i) begin
            word_q  <= '0;
            burst_q <= '0;
            state_q <= F_DATA;
          end
        end
        F_DATA: begin
          if (wr_fire) begin
            word_q <= last_word ? '0 : word_q + 1'b1;
            if (last_word) begin
              state_q <= F_CMD;
            end
          end
        end
        F_CMD: begin
          if (cmd_fire) begin
            burst_q <= burst_q + 1'b1;
            if (last_burst) begin
              done_q  <= 1'b1;
              state_q <= F_IDLE;
            end else begin
              state_q <= F_DATA;
            end
          end
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // restarts from the seed each pass, one step per accepted word
  always_ff @(posedge clk) begin
    if (state_q == F_IDLE && start_i) begin
      lfsr_q <= `MT_LFSR_SEED;
    end else if (wr_fire) begin
      lfsr_q <= lfsr_next(lfsr_q);
    end
  end

endmodule

`default_nettype wire

// ==== check_engine.sv ====
`default_nettype none

`include "mem_tester_config.svh"

module check_engine (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start_i,
  input  logic                     invert_i,
  output logic                     cmd_valid_o,
  output mem_port_pkg::mem_req_t   req_o,
  input  logic                     cmd_rdy_i,
  input  logic                     rdata_valid_i,
  input  mem_port_pkg::mem_wdata_t rdata_i,
  output logic                     done_o,
  output logic                     mismatch_o,
  output logic [`MT_ADDR_W-1:0]    mismatch_addr_o
);

  import mem_port_pkg::*;
  import mem_test_pkg::*;

  localparam int WORD_W  = $clog2(`MT_BURST_LEN);
  localparam int BURST_W = $clog2(`MT_TEST_BURSTS + 1);
  localparam int OUT_W   = $clog2(`MT_MAX_RD_OUT + 1);

  // read command side
  logic                  issue_q;
  logic [BURST_W-1:0]    cmd_burst_q;
  logic [OUT_W-1:0]      out_q;
  mem_addr_u             addr;
  logic                  cmd_fire;

  // compare side
  logic                  rx_q;
  logic [WORD_W-1:0]     rx_word_q;
  logic [BURST_W-1:0]    rx_burst_q;
  logic [`MT_DATA_W-1:0] lfsr_q;
  logic [`MT_DATA_W-1:0] expected;
  logic                  mismatch_q;
  logic [`MT_ADDR_W-1:0] mismatch_addr_q;
  logic                  done_q;
  logic                  rx_fire;
  logic                  rx_burst_end;
  logic                  word_bad;

  // stall once the in-flight limit is reached
  assign cmd_valid_o = issue_q && (out_q < OUT_W'(`MT_MAX_RD_OUT));
  assign cmd_fire    = cmd_valid_o && cmd_rdy_i;
  assign addr.lin    = burst_addr(`MT_ADDR_W'(cmd_burst_q));
  assign req_o       = '{cmd: MEM_CMD_RD, addr: phys_addr(addr)};

  assign rx_fire      = rx_q && rdata_valid_i;
  assign rx_burst_end = rx_fire && (rx_word_q == WORD_W'(`MT_BURST_LEN - 1));
  assign expected     = invert_i ? ~lfsr_next(lfsr_q) : lfsr_next(lfsr_q);
  assign word_bad     = rx_fire && (rdata_i != expected);

  assign done_o          = done_q;
  assign mismatch_o      = mismatch_q;
  assign mismatch_addr_o = mismatch_addr_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      issue_q     <= 1'b0;
      cmd_burst_q <= '0;
      out_q       <= '0;
    end else begin
      if (start_i) begin
        issue_q     <= 1'b1;
        cmd_burst_q <= '0;
      end else if (cmd_fire) begin
        cmd_burst_q <= cmd_burst_q + 1'b1;
        if (cmd_burst_q == BURST_W'(`MT_TEST_BURSTS - 1)) begin
          issue_q <= 1'b0;
        end
      end
      // up on a sent read, down when its last word is back
      if (cmd_fire && !rx_burst_end) begin
        out_q <= out_q + 1'b1;
      end else if (!cmd_fire && rx_burst_end) begin
        out_q <= out_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rx_q       <= 1'b0;
      rx_word_q  <= '0;
      rx_burst_q <= '0;
      mismatch_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        rx_q       <= 1'b1;
        rx_word_q  <= '0;
        rx_burst_q <= '0;
        mismatch_q <= 1'b0;
      end else if (rx_fire) begin
        rx_word_q <= rx_burst_end ? '0 : rx_word_q + 1'b1;
        if (word_bad) begin
          mismatch_q <= 1'b1;
        end
        if (rx_burst_end) begin
          rx_burst_q <= rx_burst_q + 1'b1;
          if (rx_burst_q == BURST_W'(`MT_TEST_BURSTS - 1)) begin
            rx_q   <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  // expected sequence steps once per arriving word
  always_ff @(posedge clk) begin
    if (start_i) begin
      lfsr_q <= `MT_LFSR_SEED;
    end else if (rx_fire) begin
      lfsr_q <= lfsr_next(lfsr_q);
    end
    // only the first bad burst is kept
    if (word_bad && !mismatch_q) begin
      mismatch_addr_q <= burst_addr(`MT_ADDR_W'(rx_burst_q));
    end
  end

endmodule

`default_nettype wire

// ==== test_sequencer.sv ====
`default_nettype none

`include "mem_tester_config.svh"

module test_sequencer (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       calib_done_i,
  output logic                       fill_start_o,
  output logic                       fill_invert_o,
  input  logic                       fill_done_i,
  output logic                       check_start_o,
  output logic                       check_invert_o,
  input  logic                       check_done_i,
  input  logic                       check_mismatch_i,
  input  logic [`MT_ADDR_W-1:0]      check_mismatch_addr_i,
  input  logic                       fill_cmd_valid_i,
  input  mem_port_pkg::mem_req_t     fill_req_i,
  input  logic                       check_cmd_valid_i,
  input  mem_port_pkg::mem_req_t     check_req_i,
  output logic                       mem_cmd_valid_o,
  output mem_port_pkg::mem_req_t     mem_req_o,
  input  logic                       mem_cmd_rdy_i,
  output logic                       fill_cmd_rdy_o,
  output logic                       check_cmd_rdy_o,
  output mem_test_pkg::test_status_t status_o
);

  import mem_port_pkg::*;
  import mem_test_pkg::*;

  test_phase_e           phase_q;
  logic [7:0]            calib_cnt_q;
  logic                  fill_start_q;
  logic                  check_start_q;
  logic                  pass_q;
  logic [`MT_ADDR_W-1:0] fail_addr_q;
  logic                  fill_sel;
  logic                  check_sel;

  assign fill_sel  = (phase_q == FILL) || (phase_q == INV_FILL);
  assign check_sel = (phase_q == CHECK) || (phase_q == INV_CHECK);

  assign fill_start_o   = fill_start_q;
  assign check_start_o  = check_start_q;
  assign fill_invert_o  = (phase_q == INV_FILL);
  assign check_invert_o = (phase_q == INV_CHECK);

  // only the engine of the current phase sees the command port
  assign fill_cmd_rdy_o  = fill_sel && mem_cmd_rdy_i;
  assign check_cmd_rdy_o = check_sel && mem_cmd_rdy_i;

  always_comb begin
    if (fill_sel) begin
      mem_cmd_valid_o = fill_cmd_valid_i;
      mem_req_o       = fill_req_i;
    end else if (check_sel) begin
      mem_cmd_valid_o = check_cmd_valid_i;
      mem_req_o       = check_req_i;
    end else begin
      mem_cmd_valid_o = 1'b0;
      mem_req_o       = '{cmd: MEM_CMD_RD, addr: '0};
    end
  end

  assign status_o = '{
    phase:     phase_q,
    done:      (phase_q == DONE),
    pass:      pass_q,
    fail_addr: fail_addr_q
  };

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase_q       <= WAIT_CALIB;
      calib_cnt_q   <= '0;
      fill_start_q  <= 1'b0;
      check_start_q <= 1'b0;
      pass_q        <= 1'b0;
      fail_addr_q   <= '0;
    end else begin
      fill_start_q  <= 1'b0;
      check_start_q <= 1'b0;
      case (phase_q)
        WAIT_CALIB: begin
          // 256 cycles of settled calibration before the first write
          if (!calib_done_i) begin
            calib_cnt_q <= '0;
          end else if (calib_cnt_q == 8'hff) begin
            phase_q      <= FILL;
            fill_start_q <= 1'b1;
          end else begin
            calib_cnt_q <= calib_cnt_q + 1'b1;
          end
        end
        FILL: begin
          if (fill_done_i) begin
            phase_q       <= CHECK;
            check_start_q <= 1'b1;
          end
        end
        CHECK: begin
          if (check_done_i && check_mismatch_i) begin
            phase_q     <= DONE;
            fail_addr_q <= check_mismatch_addr_i;
          end else if (check_done_i) begin
            phase_q      <= INV_FILL;
            fill_start_q <= 1'b1;
          end
        end
        INV_FILL: begin
          if (fill_done_i) begin
            phase_q       <= INV_CHECK;
            check_start_q <= 1'b1;
          end
        end
        INV_CHECK: begin
          if (check_done_i) begin
            phase_q <= DONE;
            pass_q  <= !check_mismatch_i;
            if (check_mismatch_i) begin
              fail_addr_q <= check_mismatch_addr_i;
            end
          end
        end
        // DONE holds until the next reset
        default: phase_q <= DONE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== mem_tester_top.sv ====
`default_nettype none

`include "mem_tester_config.svh"

module mem_tester_top (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       calib_done_i,
  output logic                       mem_cmd_valid_o,
  output mem_port_pkg::mem_req_t     mem_req_o,
  input  logic                       mem_cmd_rdy_i,
  output logic                       mem_wdata_valid_o,
  output mem_port_pkg::mem_wdata_t   mem_wdata_o,
  input  logic                       mem_wdata_rdy_i,
  input  logic                       mem_rdata_valid_i,
  input  mem_port_pkg::mem_wdata_t   mem_rdata_i,
  output mem_test_pkg::test_status_t status_o
);

  import mem_port_pkg::*;

  logic                  fill_start;
  logic                  fill_invert;
  logic                  fill_done;
  logic                  fill_cmd_valid;
  logic                  fill_cmd_rdy;
  mem_req_t              fill_req;
  logic                  check_start;
  logic                  check_invert;
  logic                  check_done;
  logic                  check_mismatch;
  logic [`MT_ADDR_W-1:0] check_mismatch_addr;
  logic                  check_cmd_valid;
  logic                  check_cmd_rdy;
  mem_req_t              check_req;

  // write side, owns the data port
  fill_engine u_fill (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (fill_start),
    .invert_i      (fill_invert),
    .wdata_valid_o (mem_wdata_valid_o),
    .wdata_o       (mem_wdata_o),
    .wdata_rdy_i   (mem_wdata_rdy_i),
    .cmd_valid_o   (fill_cmd_valid),
    .req_o         (fill_req),
    .cmd_rdy_i     (fill_cmd_rdy),
    .done_o        (fill_done)
  );

  // read side, compares on the fly
  check_engine u_check (
    .clk             (clk),
    .rstn            (rstn),
    .start_i         (check_start),
    .invert_i        (check_invert),
    .cmd_valid_o     (check_cmd_valid),
    .req_o           (check_req),
    .cmd_rdy_i       (check_cmd_rdy),
    .rdata_valid_i   (mem_rdata_valid_i),
    .rdata_i         (mem_rdata_i),
    .done_o          (check_done),
    .mismatch_o      (check_mismatch),
    .mismatch_addr_o (check_mismatch_addr)
  );

  test_sequencer u_seq (
    .clk                   (clk),
    .rstn                  (rstn),
    .calib_done_i          (calib_done_i),
    .fill_start_o          (fill_start),
    .fill_invert_o         (fill_invert),
    .fill_done_i           (fill_done),
    .check_start_o         (check_start),
    .check_invert_o        (check_invert),
    .check_done_i          (check_done),
    .check_mismatch_i      (check_mismatch),
    .check_mismatch_addr_i (check_mismatch_addr),
    .fill_cmd_valid_i      (fill_cmd_valid),
    .fill_req_i            (fill_req),
    .check_cmd_valid_i     (check_cmd_valid),
    .check_req_i           (check_req),
    .mem_cmd_valid_o       (mem_cmd_valid_o),
    .mem_req_o             (mem_req_o),
    .mem_cmd_rdy_i         (mem_cmd_rdy_i),
    .fill_cmd_rdy_o        (fill_cmd_rdy),
    .check_cmd_rdy_o       (check_cmd_rdy),
    .status_o              (status_o)
  );

endmodule

`default_nettype wire

// ==== mem_tester_sva.sv ====
`default_nettype none

`include "mem_tester_config.svh"

module mem_tester_sva (
  input logic                       clk,
  input logic                       rstn,
  input logic                       cmd_valid_i,
  input mem_port_pkg::mem_req_t     req_i,
  input logic                       cmd_rdy_i,
  input logic                       wdata_valid_i,
  input mem_port_pkg::mem_wdata_t   wdata_i,
  input logic                       wdata_rdy_i,
  input mem_test_pkg::test_status_t status_i
);

  import mem_port_pkg::*;
  import mem_test_pkg::*;

  localparam int unsigned PASS_WORDS = `MT_TEST_BURSTS * `MT_BURST_LEN;
  localparam int unsigned RUN_CMDS   = 4 * `MT_TEST_BURSTS;

  logic [`MT_DATA_W-1:0] pat_q;
  logic [`MT_DATA_W-1:0] pat_next;
  logic [`MT_DATA_W-1:0] exp_word;
  int unsigned           wr_cnt_q;
  int unsigned           cmd_cnt_q;
  mem_cmd_e              exp_cmd;
  mem_req_t              exp_req;
  int unsigned           err_cnt = 0;

  // shift left and feed in bits 68 ^ 67 ^ 66 ^ 63
  function automatic logic [`MT_DATA_W-1:0] step_pattern(input logic [`MT_DATA_W-1:0] v);
    logic fb;
    fb = v[68] ^ v[67] ^ v[66] ^ v[63];
    return {v[`MT_DATA_W-2:0], fb};
  endfunction

  // linear row/bank/col reordered as bank, row, col
  function automatic logic [`MT_ADDR_W-1:0] expected_phys(input int unsigned idx);
    logic [`MT_ADDR_W-1:0] lin;
    lin = `MT_ADDR_W'(idx * `MT_ADDR_STEP);
    return {lin[12:10], lin[26:13], lin[9:0]};
  endfunction

  assign pat_next = step_pattern(pat_q);
  // second pass of writes is the complement
  assign exp_word = (wr_cnt_q >= PASS_WORDS) ? ~pat_next : pat_next;
  // writes and reads alternate pass by pass
  assign exp_cmd  = (((cmd_cnt_q / `MT_TEST_BURSTS) % 2) == 0) ? MEM_CMD_WR : MEM_CMD_RD;
  assign exp_req  = '{cmd: exp_cmd, addr: expected_phys(cmd_cnt_q % `MT_TEST_BURSTS)};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pat_q     <= `MT_LFSR_SEED;
      wr_cnt_q  <= 0;
      cmd_cnt_q <= 0;
    end else begin
      if (wdata_valid_i && wdata_rdy_i) begin
        if ((wr_cnt_q % PASS_WORDS) == PASS_WORDS - 1) begin
          pat_q <= `MT_LFSR_SEED;
        end else begin
          pat_q <= pat_next;
        end
        wr_cnt_q <= (wr_cnt_q == 2 * PASS_WORDS - 1) ? 0 : wr_cnt_q + 1;
      end
      if (cmd_valid_i && cmd_rdy_i) begin
        cmd_cnt_q <= (cmd_cnt_q == RUN_CMDS - 1) ? 0 : cmd_cnt_q + 1;
      end
    end
  end

  idle_quiet_a : assert property (@(posedge clk)
    (!rstn || status_i.phase == WAIT_CALIB) |->
      (status_i.phase == WAIT_CALIB && !cmd_valid_i && !wdata_valid_i &&
       !status_i.done && !status_i.pass))
  else begin
    err_cnt++;
    $error("the phase, a valid, a done or a pass flag was wrong before the test started");
  end

  cmd_hold_a : assert property (@(posedge clk) disable iff (!rstn)
    (cmd_valid_i && !cmd_rdy_i) |=> (cmd_valid_i && $stable(req_i)))
  else begin
    err_cnt++;
    $error("command valid or request changed while command ready was low");
  end

  wdata_hold_a : assert property (@(posedge clk) disable iff (!rstn)
    (wdata_valid_i && !wdata_rdy_i) |=> (wdata_valid_i && $stable(wdata_i)))
  else begin
    err_cnt++;
    $error("write valid or write data changed while write ready was low");
  end

  wdata_value_a : assert property (@(posedge clk) disable iff (!rstn)
    (wdata_valid_i && wdata_rdy_i) |-> (wdata_i == exp_word))
  else begin
    err_cnt++;
    $error("mismatch write_data: expected %h, actual %h",
           $sampled(exp_word), $sampled(wdata_i));
  end

  cmd_value_a : assert property (@(posedge clk) disable iff (!rstn)
    (cmd_valid_i && cmd_rdy_i) |-> (req_i == exp_req))
  else begin
    err_cnt++;
    $error("mismatch command: expected %h, actual %h",
           $sampled(exp_req), $sampled(req_i));
  end

endmodule

bind mem_tester_top mem_tester_sva sva_i (
  .clk           (clk),
  .rstn          (rstn),
  .cmd_valid_i   (mem_cmd_valid_o),
  .req_i         (mem_req_o),
  .cmd_rdy_i     (mem_cmd_rdy_i),
  .wdata_valid_i (mem_wdata_valid_o),
  .wdata_i       (mem_wdata_o),
  .wdata_rdy_i   (mem_wdata_rdy_i),
  .status_i      (status_o)
);

`default_nettype wire

// ==== tb_mem_tester.sv ====
`default_nettype none

`include "mem_tester_config.svh"

module tb_mem_tester;

  import mem_port_pkg::*;
  import mem_test_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          DRIVE_DLY    = 10;
  localparam int          RESET_CYCLES = 16;
  localparam int unsigned RANDOM_SEED  = 32'h576;
  // address units between consecutive words of a burst
  localparam int          WORD_STEP    = `MT_ADDR_STEP / `MT_BURST_LEN;
  localparam int          PASS_WORDS   = `MT_TEST_BURSTS * `MT_BURST_LEN;
  // 40 cycles per word covers back-pressure and read latency
  localparam int          RUN_CYCLES   = PASS_WORDS * 4 * 40 + 1024;
  localparam int          WATCHDOG_CYCLES = 2 * RUN_CYCLES;

  logic         clk;
  logic         rstn;
  logic         calib_done;
  logic         mem_cmd_valid;
  mem_req_t     mem_req;
  logic         mem_cmd_rdy;
  logic         mem_wdata_valid;
  mem_wdata_t   mem_wdata;
  logic         mem_wdata_rdy;
  logic         mem_rdata_valid;
  mem_wdata_t   mem_rdata;
  test_status_t status;

  // memory model state keyed by linear address
  mem_wdata_t            mem_q[logic [`MT_ADDR_W-1:0]];
  mem_wdata_t            wbuf_q[$];
  logic [`MT_ADDR_W-1:0] rd_addr_q[$];
  longint unsigned       rd_due_q[$];
  longint unsigned       cycle_cnt = 0;
  logic                  rd_busy = 1'b0;
  int                    rd_word = 0;
  logic [`MT_ADDR_W-1:0] rd_base = '0;

  mem_tester_top dut_i (
    .clk               (clk),
    .rstn              (rstn),
    .calib_done_i      (calib_done),
    .mem_cmd_valid_o   (mem_cmd_valid),
    .mem_req_o         (mem_req),
    .mem_cmd_rdy_i     (mem_cmd_rdy),
    .mem_wdata_valid_o (mem_wdata_valid),
    .mem_wdata_o       (mem_wdata),
    .mem_wdata_rdy_i   (mem_wdata_rdy),
    .mem_rdata_valid_i (mem_rdata_valid),
    .mem_rdata_i       (mem_rdata),
    .status_o          (status)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // bank/row/col physical back to row/bank/col linear
  function automatic logic [`MT_ADDR_W-1:0] lin_of_phys(input logic [`MT_ADDR_W-1:0] p);
    return {p[23:10], p[26:24], p[9:0]};
  endfunction

  function automatic mem_wdata_t read_word(input logic [`MT_ADDR_W-1:0] a);
    if (mem_q.exists(a)) begin
      return mem_q[a];
    end
    return '0;
  endfunction

  task automatic clear_model();
    mem_q.delete();
    wbuf_q.delete();
    rd_addr_q.delete();
    rd_due_q.delete();
    rd_busy = 1'b0;
  endtask

  // outputs settle by the falling edge and transfer at the next rise
  task automatic sample_port();
    logic [`MT_ADDR_W-1:0] lin;
    if (mem_wdata_valid && mem_wdata_rdy) begin
      wbuf_q.push_back(mem_wdata);
    end
    if (mem_cmd_valid && mem_cmd_rdy) begin
      lin = lin_of_phys(mem_req.addr);
      if (mem_req.cmd == MEM_CMD_WR) begin
        assert (wbuf_q.size() >= `MT_BURST_LEN)
        else fail_run("write command arrived before all words of its burst");
        for (int w = 0; w < `MT_BURST_LEN; w++) begin
          mem_q[lin + `MT_ADDR_W'(w * WORD_STEP)] = wbuf_q.pop_front();
        end
      end else begin
        rd_addr_q.push_back(lin);
        rd_due_q.push_back(cycle_cnt + 4 + $urandom_range(16));
      end
    end
  endtask

  task automatic drive_port();
    cycle_cnt++;
    mem_cmd_rdy   = ($urandom_range(3) != 0);
    mem_wdata_rdy = ($urandom_range(3) != 0);
    // bursts come back in order once their latency is over
    if (!rd_busy && rd_addr_q.size() > 0 && rd_due_q[0] <= cycle_cnt) begin
      rd_busy = 1'b1;
      rd_word = 0;
      rd_base = rd_addr_q.pop_front();
      void'(rd_due_q.pop_front());
    end
    if (rd_busy) begin
      mem_rdata_valid = 1'b1;
      mem_rdata       = read_word(rd_base + `MT_ADDR_W'(rd_word * WORD_STEP));
      rd_word++;
      if (rd_word == `MT_BURST_LEN) begin
        rd_busy = 1'b0;
      end
    end else begin
      mem_rdata_valid = 1'b0;
      mem_rdata       = '0;
    end
  endtask

  task automatic run_memory();
    forever begin
      @(negedge clk);
      if (rstn) begin
        sample_port();
      end else begin
        clear_model();
      end
      @(posedge clk);
      #DRIVE_DLY;
      drive_port();
    end
  endtask

  task automatic reset_and_calibrate();
    @(posedge clk);
    #DRIVE_DLY;
    rstn       = 1'b0;
    calib_done = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rstn = 1'b1;
    repeat ($urandom_range(200, 20)) @(posedge clk);
    #DRIVE_DLY;
    calib_done = 1'b1;
  endtask

  task automatic wait_for_done();
    do begin
      @(negedge clk);
    end while (!status.done);
  endtask

  task automatic check_clean_run();
    logic [`MT_ADDR_W-1:0] addr;
    assert (status.pass === 1'b1)
    else fail_run($sformatf("mismatch clean_pass: expected 1, actual %b", status.pass));
    assert (mem_q.num() == PASS_WORDS)
    else fail_run($sformatf("mismatch clean_words: expected %0d, actual %0d",
                            PASS_WORDS, mem_q.num()));
    for (int b = 0; b < `MT_TEST_BURSTS; b++) begin
      for (int w = 0; w < `MT_BURST_LEN; w++) begin
        addr = `MT_ADDR_W'(b * `MT_ADDR_STEP + w * WORD_STEP);
        assert (mem_q.exists(addr))
        else fail_run($sformatf("address %h was never written", addr));
      end
    end
  endtask

  task automatic check_corrupted_run(input logic [`MT_ADDR_W-1:0] bad_burst_addr);
    assert (status.pass === 1'b0)
    else fail_run($sformatf("mismatch fault_pass: expected 0, actual %b", status.pass));
    assert (status.fail_addr === bad_burst_addr)
    else fail_run($sformatf("mismatch fault_addr: expected %h, actual %h",
                            bad_burst_addr, status.fail_addr));
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run($sformatf("timeout, the runs did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin : assertion_watch
    wait (dut_i.sva_i.err_cnt != 0);
    fail_run("a bound assertion failed");
  end

  initial begin : main
    int unsigned           bad_burst;
    int unsigned           bad_word;
    int unsigned           bad_bit;
    logic [`MT_ADDR_W-1:0] bad_addr;

    void'($urandom(RANDOM_SEED));
    rstn            = 1'b1;
    calib_done      = 1'b0;
    mem_cmd_rdy     = 1'b0;
    mem_wdata_rdy   = 1'b0;
    mem_rdata_valid = 1'b0;
    mem_rdata       = '0;
    fork
      run_memory();
    join_none

    reset_and_calibrate();
    wait_for_done();
    check_clean_run();

    // second run flips one bit as the inverse check begins
    reset_and_calibrate();
    do begin
      @(negedge clk);
    end while (status.phase != INV_CHECK);
    bad_burst = $urandom_range(`MT_TEST_BURSTS - 1);
    bad_word  = $urandom_range(`MT_BURST_LEN - 1);
    bad_bit   = $urandom_range(`MT_DATA_W - 1);
    bad_addr  = `MT_ADDR_W'(bad_burst * `MT_ADDR_STEP + bad_word * WORD_STEP);
    assert (mem_q.exists(bad_addr))
    else fail_run($sformatf("address %h to corrupt holds no data", bad_addr));
    mem_q[bad_addr] = mem_q[bad_addr] ^ (mem_wdata_t'(1) << bad_bit);
    wait_for_done();
    check_corrupted_run(`MT_ADDR_W'(bad_burst * `MT_ADDR_STEP));

    if (dut_i.sva_i.err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      fail_run("a bound assertion reported an error");
    end
  end

endmodule

`default_nettype wire

// ==== mem_tester.f ====
+incdir+.
mem_port_pkg.sv
mem_test_pkg.sv
fill_engine.sv
check_engine.sv
test_sequencer.sv
mem_tester_top.sv
mem_tester_sva.sv
tb_mem_tester.sv

// ==== Bender.yml ====
package:
  name: mem_tester

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_port_pkg.sv
      - mem_test_pkg.sv
      - fill_engine.sv
      - check_engine.sv
      - test_sequencer.sv
      - mem_tester_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_tester_sva.sv
      - tb_mem_tester.sv
